// File: source/kbd_defs.svh
// Size and timing macros for the PS/2 keyboard front end
// Row layout, APB address width and receiver idle timeout

`ifndef KBD_DEFS_SVH
`define KBD_DEFS_SVH

// Key matrix shape
`define KBD_ROWS 4 // Three joystick rows plus system row
`define KBD_ROW_W 10 // Keys held per row

// Host bus
`define KBD_ADDR_W 8 // APB byte address bits

// PS/2 receiver
// A PS/2 bit lasts tens of microseconds, so a gap this long
// in the middle of a frame means the receiver lost alignment
`define KBD_PS2_TIMEOUT 4096 // Idle clk cycles before a frame is dropped

`endif

// File: source/kbd_pkg.sv
// Shared types of the keyboard front end
// Byte, key code, row state and APB address types, receiver states, key table

`include "kbd_defs.svh"

package kbd_pkg;

    typedef logic [7:0] ps2_byte_t; // One byte off the PS/2 line
    typedef logic [8:0] key_code_t; // Extended flag above the code byte
    typedef logic [`KBD_ROW_W-1:0] row_state_t; // Set bit means key held
    typedef logic [`KBD_ADDR_W-1:0] apb_addr_t;

    typedef enum logic [1:0] {
        rx_idle, // Waiting for a start bit
        rx_data, // Eight data bits, LSB first
        rx_parity, // Odd parity bit
        rx_stop // Stop bit, must be high
    } ps2_rx_state_t;

    // Entry b of a row drives bit b of that row
    // Code 0 marks an unused slot and never matches
    localparam key_code_t KEY_TABLE [`KBD_ROWS][`KBD_ROW_W] = '{
        '{9'h174, 9'h16b, 9'h172, 9'h175, 9'h014, // Right, left, down, up, L-ctrl
          9'h011, 9'h029, 9'h012, 9'h01a, 9'h022}, // Alt, space, L-shift, Z, X
        '{9'h034, 9'h023, 9'h02b, 9'h02d, 9'h01c, // Player 2 arrows on G D F R, A
          9'h01b, 9'h015, 9'h01d, 9'h024, 9'h042}, // S, Q, W, E, K as button 6
        '{9'h04b, 9'h03b, 9'h042, 9'h043, 9'h114, // Player 3 L J K I, R-ctrl
          9'h059, 9'h05a, 9'h000, 9'h000, 9'h000}, // R-shift, return, unused
        '{9'h016, 9'h01e, 9'h026, 9'h025, 9'h02e, // Start 1 to 4, coin 1
          9'h036, 9'h03d, 9'h03e, 9'h04d, 9'h046} // Coin 2 to 4, pause P, service 9
    };

endpackage

// File: source/ps2_rx.sv
// PS/2 device-to-host receiver
// Synchronizes the lines, shifts in 11-bit frames, checks parity and stop bit

`include "kbd_defs.svh"

module ps2_rx (
    input  logic               clk,
    input  logic               rst,
    input  logic               ps2_clk,
    input  logic               ps2_data,
    output kbd_pkg::ps2_byte_t byte_data,
    output logic               byte_valid,
    output logic               frame_error
);

    localparam int TO_W = $clog2(`KBD_PS2_TIMEOUT);

    logic [1:0]             clk_sync; // Bit 1 is the synchronized line
    logic [1:0]             data_sync;
    logic                   clk_prev; // Delayed copy for edge detection
    logic                   clk_fall;
    logic                   clk_edge;
    logic                   data_bit;
    kbd_pkg::ps2_rx_state_t state;
    logic [2:0]             bit_cnt; // Data bit index
    kbd_pkg::ps2_byte_t     shift_reg;
    logic                   parity_bit;
    logic [TO_W-1:0]        idle_cnt; // Cycles since last ps2_clk edge
    logic                   timeout;

    assign clk_fall  = clk_prev & ~clk_sync[1]; // Device drives data before falling edge
    assign clk_edge  = clk_prev ^ clk_sync[1];
    assign data_bit  = data_sync[1];
    assign timeout   = (idle_cnt == TO_W'(`KBD_PS2_TIMEOUT - 1));
    assign byte_data = shift_reg; // Holds until the next start bit

    always_ff @(posedge clk) begin
        if (rst) begin
            clk_sync  <= 2'b11; // Lines idle high
            data_sync <= 2'b11;
            clk_prev  <= 1'b1;
        end else begin
            clk_sync  <= {clk_sync[0], ps2_clk};
            data_sync <= {data_sync[0], ps2_data};
            clk_prev  <= clk_sync[1];
        end
    end

    // Watchdog only runs inside a frame
    always_ff @(posedge clk) begin
        if (rst || clk_edge || state == kbd_pkg::rx_idle) begin
            idle_cnt <= '0;
        end else if (!timeout) begin
            idle_cnt <= idle_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= kbd_pkg::rx_idle;
            bit_cnt     <= 3'd0;
            byte_valid  <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            byte_valid  <= 1'b0; // Single-cycle pulses
            frame_error <= 1'b0;
            if (timeout) begin
                state <= kbd_pkg::rx_idle; // Drop partial frame silently
            end else if (clk_fall) begin
                case (state)
                    kbd_pkg::rx_idle: begin
                        if (!data_bit) begin // Start bit is low
                            state   <= kbd_pkg::rx_data;
                            bit_cnt <= 3'd0;
                        end
                    end
                    kbd_pkg::rx_data: begin
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            state <= kbd_pkg::rx_parity;
                        end
                    end
                    kbd_pkg::rx_parity: state <= kbd_pkg::rx_stop;
                    kbd_pkg::rx_stop: begin
                        // Odd parity over data and parity bit
                        if (data_bit && (^{parity_bit, shift_reg})) begin
                            byte_valid <= 1'b1;
                        end else begin
                            frame_error <= 1'b1;
                        end
                        state <= kbd_pkg::rx_idle;
                    end
                    default: state <= kbd_pkg::rx_idle;
                endcase
            end
        end
    end

    // Frame payload
    always_ff @(posedge clk) begin
        if (clk_fall && state == kbd_pkg::rx_data) begin
            shift_reg <= {data_bit, shift_reg[7:1]}; // LSB arrives first
        end
        if (clk_fall && state == kbd_pkg::rx_parity) begin
            parity_bit <= data_bit;
        end
    end

endmodule

// File: source/scan_decoder.sv
// Scan code set 2 decoder
// Folds E0 and F0 prefixes into one key event per code

module scan_decoder (
    input  logic               clk,
    input  logic               rst,
    input  kbd_pkg::ps2_byte_t byte_data,
    input  logic               byte_valid,
    output kbd_pkg::key_code_t key_code,
    output logic               key_make,
    output logic               key_valid
);

    localparam kbd_pkg::ps2_byte_t EXT_PREFIX = 8'he0;
    localparam kbd_pkg::ps2_byte_t REL_PREFIX = 8'hf0;

    logic ext_flag; // E0 seen since last event
    logic rel_flag; // F0 seen since last event
    logic is_prefix;

    assign is_prefix = (byte_data == EXT_PREFIX) || (byte_data == REL_PREFIX);

    always_ff @(posedge clk) begin
        if (rst) begin
            ext_flag  <= 1'b0;
            rel_flag  <= 1'b0;
            key_valid <= 1'b0;
        end else begin
            key_valid <= 1'b0;
            if (byte_valid) begin
                if (byte_data == EXT_PREFIX) begin
                    ext_flag <= 1'b1;
                end else if (byte_data == REL_PREFIX) begin
                    rel_flag <= 1'b1;
                end else begin
                    ext_flag  <= 1'b0; // Final byte closes the sequence
                    rel_flag  <= 1'b0;
                    key_valid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (byte_valid && !is_prefix) begin
            key_code <= {ext_flag, byte_data};
            key_make <= ~rel_flag; // Press unless F0 came first
        end
    end

endmodule

// File: source/key_row_map.sv
// Pressed state of one row of ten keys
// Matches key events against the row's entries of the key table

`include "kbd_defs.svh"

module key_row_map #(
    parameter int ROW = 0 // Row of KEY_TABLE served here
) (
    input  logic                clk,
    input  logic                rst,
    input  kbd_pkg::key_code_t  key_code,
    input  logic                key_make,
    input  logic                key_valid,
    output kbd_pkg::row_state_t row_state
);

    logic [`KBD_ROW_W-1:0] hit; // Per-key code match

    if (ROW < 0 || ROW >= `KBD_ROWS) begin : g_bad_row
        $error("key_row_map ROW %0d outside key table", ROW);
    end

    // A key may sit in more than one row, each row matches on its own
    for (genvar b = 0; b < `KBD_ROW_W; b++) begin : g_hit
        assign hit[b] = (kbd_pkg::KEY_TABLE[ROW][b] != '0) &&
                        (key_code == kbd_pkg::KEY_TABLE[ROW][b]);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            row_state <= '0; // All keys released
        end else if (key_valid) begin
            for (int b = 0; b < `KBD_ROW_W; b++) begin
                if (hit[b]) begin
                    row_state[b] <= key_make; // Set on press, clear on release
                end
            end
        end
    end

endmodule

// File: source/kbd_apb_regs.sv
// APB slave of the keyboard front end
// Row state registers, sticky change flag, saturating frame error count

`include "kbd_defs.svh"

module kbd_apb_regs (
    input  logic                clk,
    input  logic                rst,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  kbd_pkg::apb_addr_t  paddr,
    input  logic [31:0]         pwdata,
    output logic [31:0]         prdata,
    output logic                pready,
    output logic                pslverr,
    input  kbd_pkg::row_state_t row_state [`KBD_ROWS],
    input  logic                frame_error
);

    localparam int IDX_W = $clog2(`KBD_ROWS);
    localparam kbd_pkg::apb_addr_t STATUS_ADDR = kbd_pkg::apb_addr_t'(8'h10);

    logic                access; // APB access phase
    logic                is_row;
    logic                is_status;
    logic                clear; // Write to status
    logic                row_changed;
    logic [IDX_W-1:0]    row_idx;
    logic                change_flag;
    logic [7:0]          err_cnt;
    kbd_pkg::row_state_t row_prev [`KBD_ROWS]; // Last cycle's rows

    assign access    = psel && penable;
    assign row_idx   = paddr[IDX_W+1:2]; // One word per row
    assign is_row    = (paddr[1:0] == 2'b00) && (paddr[`KBD_ADDR_W-1:2] < `KBD_ROWS);
    assign is_status = (paddr == STATUS_ADDR);
    // Any write clears status whatever the data word holds
    assign clear     = access && pwrite && is_status;

    assign pready  = access; // No wait states
    assign pslverr = access && !is_status && (pwrite || !is_row); // Rows are read only

    always_comb begin
        row_changed = 1'b0;
        for (int i = 0; i < `KBD_ROWS; i++) begin
            if (row_state[i] != row_prev[i]) begin
                row_changed = 1'b1;
            end
        end
    end

    // Read mux
    always_comb begin
        prdata = '0;
        if (is_row) begin
            prdata[`KBD_ROW_W-1:0] = row_state[row_idx];
        end else if (is_status) begin
            prdata[0]    = change_flag;
            prdata[15:8] = err_cnt;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            change_flag <= 1'b0;
            err_cnt     <= 8'd0;
            for (int i = 0; i < `KBD_ROWS; i++) begin
                row_prev[i] <= '0; // Rows also reset to zero
            end
        end else begin
            for (int i = 0; i < `KBD_ROWS; i++) begin
                row_prev[i] <= row_state[i];
            end
            if (row_changed) begin
                change_flag <= 1'b1; // New change beats a clear
            end else if (clear) begin
                change_flag <= 1'b0;
            end
            if (clear) begin
                err_cnt <= {7'd0, frame_error}; // Keep an error landing on the clear
            end else if (frame_error && err_cnt != 8'hff) begin
                err_cnt <= err_cnt + 8'd1; // Saturates at 255
            end
        end
    end

endmodule

// File: source/kbd_top.sv
// Keyboard front end top level
// Receiver, scan decoder, row mappers and APB registers

`include "kbd_defs.svh"

module kbd_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               ps2_clk,
    input  logic               ps2_data,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  kbd_pkg::apb_addr_t paddr,
    input  logic [31:0]        pwdata,
    output logic [31:0]        prdata,
    output logic               pready,
    output logic               pslverr
);

    kbd_pkg::ps2_byte_t  byte_data;
    logic                byte_valid;
    logic                frame_error;
    kbd_pkg::key_code_t  key_code;
    logic                key_make;
    logic                key_valid;
    kbd_pkg::row_state_t row_state [`KBD_ROWS];

    ps2_rx ps2_rx_i (
        .clk         (clk),
        .rst         (rst),
        .ps2_clk     (ps2_clk),
        .ps2_data    (ps2_data),
        .byte_data   (byte_data),
        .byte_valid  (byte_valid),
        .frame_error (frame_error)
    );

    scan_decoder scan_decoder_i (
        .clk        (clk),
        .rst        (rst),
        .byte_data  (byte_data),
        .byte_valid (byte_valid),
        .key_code   (key_code),
        .key_make   (key_make),
        .key_valid  (key_valid)
    );

    // Same event broadcast to every row
    for (genvar i = 0; i < `KBD_ROWS; i++) begin : g_row
        key_row_map #(.ROW(i)) key_row_map_i (
            .clk       (clk),
            .rst       (rst),
            .key_code  (key_code),
            .key_make  (key_make),
            .key_valid (key_valid),
            .row_state (row_state[i])
        );
    end

    kbd_apb_regs kbd_apb_regs_i (
        .clk         (clk),
        .rst         (rst),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .row_state   (row_state),
        .frame_error (frame_error)
    );

endmodule

// File: tb/kbd_assert.sv
// Concurrent checks on receiver, decoder and APB handshake
// Bound into the keyboard top level

module kbd_assert (
    input logic clk,
    input logic rst,
    input logic byte_valid,
    input logic frame_error,
    input logic key_valid,
    input logic psel,
    input logic penable,
    input logic pslverr
);

    timeunit 1ns;
    timeprecision 1ps;

    int fail_cnt = 0; // Read by the testbench at the end

    // A frame ends either good or bad, never both
    rx_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(byte_valid && frame_error))
    else begin
        $error("byte_valid and frame_error high in the same cycle");
        fail_cnt++;
    end

    key_pulse: assert property (@(posedge clk) disable iff (rst)
        key_valid |=> !key_valid) // One event per code
    else begin
        $error("key_valid held longer than one cycle");
        fail_cnt++;
    end

    apb_err_phase: assert property (@(posedge clk) disable iff (rst)
        pslverr |-> (psel && penable)) // Only in access phase
    else begin
        $error("pslverr outside an APB access phase");
        fail_cnt++;
    end

endmodule

bind kbd_top kbd_assert kbd_assert_i (
    .clk         (clk),
    .rst         (rst),
    .byte_valid  (byte_valid),
    .frame_error (frame_error),
    .key_valid   (key_valid),
    .psel        (psel),
    .penable     (penable),
    .pslverr     (pslverr)
);

// File: tb/kbd_tb.sv
// Testbench of the PS/2 keyboard front end
// Sends PS/2 frames from a stimulus table and checks the APB registers

`include "kbd_defs.svh"

module kbd_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_TESTS  = 24;
    localparam int POLL_LIMIT = 64; // Reads before a poll gives up
    localparam int WAIT_LIMIT = 32; // Cycles allowed for pready

    typedef struct {
        string       name;
        int          n; // Frames to send
        logic [23:0] seq; // First byte in the low bits
        logic        bad; // Invert parity
        logic        wr; // Write instead of read
        logic [7:0]  addr;
        logic [31:0] exp; // Expected read data
        logic        err; // pslverr expected
    } test_t;

    logic                clk;
    logic                rst;
    logic                ps2_clk;
    logic                ps2_data;
    logic                psel;
    logic                penable;
    logic                pwrite;
    kbd_pkg::apb_addr_t  paddr;
    logic [31:0]         pwdata;
    logic [31:0]         prdata;
    logic                pready;
    logic                pslverr;

    test_t tests [MAX_TESTS];
    int    n_tests;
    int    n_run;
    int    errors;
    logic  timed_out;

    kbd_top kbd_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk; // 4 ns period
    end

    // Bits of a row that a code should drive, looked up in the key table
    function automatic logic [31:0] key_mask(input int row, input kbd_pkg::key_code_t code);
        logic [31:0] m;
        m = '0;
        for (int b = 0; b < `KBD_ROW_W; b++) begin
            if (kbd_pkg::KEY_TABLE[row][b] == code) begin
                m[b] = 1'b1;
            end
        end
        return m;
    endfunction

    task automatic add_test(input string name, input int n, input logic [23:0] seq,
                            input logic bad, input logic wr, input logic [7:0] addr,
                            input logic [31:0] exp, input logic err);
        tests[n_tests] = '{name, n, seq, bad, wr, addr, exp, err};
        n_tests++;
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (act !== exp) begin
            $display("[ERROR] %0s expected %08h actual %08h", name, exp, act);
            errors++;
        end
    endtask

    // Device-driven frame, data changes while ps2_clk is high
    task automatic send_frame(input logic [7:0] data, input logic bad);
        int          period;
        int          low;
        logic [10:0] bits;
        period = 16 + int'($urandom % 16); // 16 to 31 clk cycles per bit
        low    = period / 2;
        bits   = {1'b1, (~^data) ^ bad, data, 1'b0}; // Stop, odd parity, data, start
        @(negedge clk);
        for (int i = 0; i < 11; i++) begin
            ps2_data = bits[i];
            repeat (period - low) @(negedge clk);
            ps2_clk = 1'b0; // Receiver samples here
            repeat (low) @(negedge clk);
            ps2_clk = 1'b1;
        end
        repeat (period) @(negedge clk); // Idle gap between frames
    endtask

    task automatic apb_access(input logic wr, input logic [7:0] addr,
                              output logic [31:0] rdata, output logic err);
        int t;
        rdata = '0;
        err   = 1'b0;
        @(negedge clk);
        psel    = 1'b1; // Setup phase
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wr ? 32'h1 : 32'h0;
        @(negedge clk);
        penable = 1'b1;
        t = 0;
        do begin
            @(posedge clk);
            t++;
        end while (!pready && t < WAIT_LIMIT);
        if (!pready) begin
            $display("APB slave gave no pready at address %02h", addr);
            timed_out = 1'b1;
        end
        rdata = prdata;
        err   = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    initial begin : run
        int          errs_before;
        int          polls;
        logic [31:0] rd;
        logic        rerr;
        void'($urandom(32'h45cf_5d28));
        rst       = 1'b1;
        ps2_clk   = 1'b1; // PS/2 lines idle high
        ps2_data  = 1'b1;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        n_tests   = 0;
        n_run     = 0;
        errors    = 0;
        timed_out = 1'b0;

        // Rows keep their state from one entry to the next
        add_test("reset_status", 0, 24'h0, 0, 0, 8'h10, 32'h0, 0);
        add_test("make_start1", 1, 24'h16, 0, 0, 8'h0c, key_mask(3, 9'h016), 0);
        add_test("make_k_row1", 1, 24'h42, 0, 0, 8'h04, key_mask(1, 9'h042), 0);
        add_test("make_k_row2", 0, 24'h0, 0, 0, 8'h08, key_mask(2, 9'h042), 0);
        add_test("make_coin1", 1, 24'h2e, 0, 0, 8'h0c,
                 key_mask(3, 9'h016) | key_mask(3, 9'h02e), 0);
        add_test("break_start1", 2, 24'h16f0, 0, 0, 8'h0c, key_mask(3, 9'h02e), 0);
        add_test("make_rctrl", 2, 24'h14e0, 0, 0, 8'h08,
                 key_mask(2, 9'h042) | key_mask(2, 9'h114), 0);
        add_test("make_lctrl", 1, 24'h14, 0, 0, 8'h00, key_mask(0, 9'h014), 0);
        add_test("status_changed", 0, 24'h0, 0, 0, 8'h10, 32'h1, 0);
        add_test("clear_status", 0, 24'h0, 0, 1, 8'h10, 32'h0, 0);
        add_test("status_cleared", 0, 24'h0, 0, 0, 8'h10, 32'h0, 0);
        add_test("bad_parity", 1, 24'h16, 1, 0, 8'h0c, key_mask(3, 9'h02e), 0);
        add_test("error_count", 0, 24'h0, 0, 0, 8'h10, 32'h100, 0); // Count in 15:8
        add_test("clear_errors", 0, 24'h0, 0, 1, 8'h10, 32'h0, 0);
        add_test("errors_cleared", 0, 24'h0, 0, 0, 8'h10, 32'h0, 0);
        add_test("unknown_code", 1, 24'h0e, 0, 0, 8'h10, 32'h0, 0);
        add_test("unmapped_read", 0, 24'h0, 0, 0, 8'h14, 32'h0, 1);
        add_test("row_write", 0, 24'h0, 0, 1, 8'h04, 32'h0, 1);
        add_test("break_k", 2, 24'h42f0, 0, 0, 8'h08, key_mask(2, 9'h114), 0);

        repeat (4) @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < n_tests && !timed_out; i++) begin
            errs_before = errors;
            for (int k = 0; k < tests[i].n; k++) begin
                send_frame(tests[i].seq[8*k +: 8], tests[i].bad);
            end
            polls = 0;
            do begin // Reads repeat until the register settles
                apb_access(tests[i].wr, tests[i].addr, rd, rerr);
                polls++;
            end while (!tests[i].wr && !tests[i].err && !timed_out &&
                       rd !== tests[i].exp && polls < POLL_LIMIT);
            if (!timed_out) begin
                if (!tests[i].wr && !tests[i].err) begin
                    check_value(tests[i].name, tests[i].exp, rd);
                end
                check_value(tests[i].name, {31'd0, tests[i].err}, {31'd0, rerr});
                n_run++;
                $display("%0s %0s", (errors == errs_before) ? "ok  " : "FAIL", tests[i].name);
            end
        end

        errors += kbd_top_i.kbd_assert_i.fail_cnt; // Assertion failures count too
        $display("%0d of %0d tests run, %0d errors", n_run, n_tests, errors);
        if (errors == 0 && !timed_out) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+source
source/kbd_pkg.sv
source/ps2_rx.sv
source/scan_decoder.sv
source/key_row_map.sv
source/kbd_apb_regs.sv
source/kbd_top.sv
tb/kbd_assert.sv
tb/kbd_tb.sv

// File: Bender.yml
package:
  name: kbd_ps2

export_include_dirs:
  - source

sources:
  - files:
      - source/kbd_pkg.sv
      - source/ps2_rx.sv
      - source/scan_decoder.sv
      - source/key_row_map.sv
      - source/kbd_apb_regs.sv
      - source/kbd_top.sv
  - target: test
    files:
      - tb/kbd_assert.sv
      - tb/kbd_tb.sv
